// ==== common/vector_pkg.sv ====
package vector_pkg;

    // signed 8.24 fixed point
    typedef logic signed [31:0] fp;
    typedef logic [15:0] pixel_tag;

    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    typedef struct packed {
        pixel_tag tag;
        vec3      p;
        vec3      light_pos;
    } shade_req;

    typedef struct packed {
        pixel_tag tag;
        vec3      normal;
        vec3      light_dir;
    } surface_sample;

    typedef struct packed {
        pixel_tag tag;
        fp        intensity;
        vec3      normal;
    } shade_result;

    localparam fp FP_ONE     = 32'sh0100_0000;
    localparam fp FP_NEG_ONE = 32'shff00_0000;
    localparam fp PROBE_EPS  = 32'sh0000_4189;
    // 64.0, lifts the tiny probe sum into a range the square keeps precise
    localparam fp NORMAL_GAIN = 32'sh4000_0000;
    // 0.25, keeps the squared light distance inside the 8.24 range
    localparam fp LIGHT_GAIN = 32'sh0040_0000;

    // 1.75, radius squared sits mid-segment of the inverse square root seed table
    localparam fp SPHERE_RADIUS = 32'sh01c0_0000;

    localparam int ISQRT_LAT  = 3;
    localparam int SCENE_LAT  = ISQRT_LAT + 2;
    localparam int SURF_LAT   = SCENE_LAT + ISQRT_LAT + 2;
    localparam int FIFO_DEPTH = 16;

    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr;
    typedef logic [$clog2(FIFO_DEPTH):0] slot_count;

    function automatic fp fp_mul(fp a, fp b);
        logic signed [63:0] prod;
        prod = a * b;
        return fp'(prod >>> 24);
    endfunction

    function automatic vec3 make_vec3(fp x, fp y, fp z);
        vec3 v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    function automatic vec3 vec3_add(vec3 a, vec3 b);
        return make_vec3(a.x + b.x, a.y + b.y, a.z + b.z);
    endfunction

    function automatic vec3 vec3_sub(vec3 a, vec3 b);
        return make_vec3(a.x - b.x, a.y - b.y, a.z - b.z);
    endfunction

    function automatic vec3 vec3_scale(vec3 v, fp s);
        return make_vec3(fp_mul(v.x, s), fp_mul(v.y, s), fp_mul(v.z, s));
    endfunction

    function automatic fp vec3_dot(vec3 a, vec3 b);
        return fp_mul(a.x, b.x) + fp_mul(a.y, b.y) + fp_mul(a.z, b.z);
    endfunction

    localparam vec3 SPHERE_CENTER = make_vec3(32'sh0080_0000, 32'shffc0_0000, FP_ONE);

    // tetrahedron corners for the gradient estimate
    localparam vec3 TETRA_DIR [4] = '{
        make_vec3(FP_ONE, FP_NEG_ONE, FP_NEG_ONE),
        make_vec3(FP_NEG_ONE, FP_ONE, FP_NEG_ONE),
        make_vec3(FP_NEG_ONE, FP_NEG_ONE, FP_ONE),
        make_vec3(FP_ONE, FP_ONE, FP_ONE)
    };

endpackage

// ==== design/inv_sqrt.sv ====
`timescale 1ns/1ps

module inv_sqrt
    import vector_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  fp    x,
    output fp    inv_sqrt
);

    fp           seed_table [32];
    logic [4:0]  msb;
    logic [31:0] norm;
    logic [4:0]  seed_idx;
    int          half_shift;
    fp           seed;
    fp           x_s1;
    fp           y0_s1;
    fp           y0_s2;
    fp           t_s2;

    // 1/sqrt(m) at the middle of each segment, m in [1,4)
    // index is {odd exponent, top four mantissa bits}
    function automatic fp seed_value(int idx);
        longint unsigned num;
        longint unsigned root;
        longint unsigned trial;
        num  = (64'd1 << (53 - idx / 16)) / 64'(33 + 2 * (idx % 16));
        root = 0;
        for (int b = 24; b >= 0; b--) begin
            trial = root | (64'd1 << b);
            if (trial * trial <= num) begin
                root = trial;
            end
        end
        return fp'(root);
    endfunction

    for (genvar i = 0; i < 32; i++) begin : g_seed
        localparam fp SEED = seed_value(i);
        assign seed_table[i] = SEED;
    end

    always_comb begin
        msb = '0;
        for (int i = 0; i < 31; i++) begin
            if (x[i]) begin
                msb = 5'(i);
            end
        end
        norm       = x << (30 - msb);
        seed_idx   = {msb[0], norm[29:26]};
        // even exponent after folding an odd one into the mantissa
        half_shift = (24 + int'(msb[0]) - int'(msb)) / 2;
        if (half_shift >= 0) begin
            seed = seed_table[seed_idx] <<< half_shift;
        end else begin
            seed = seed_table[seed_idx] >>> (-half_shift);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x_s1     <= '0;
            y0_s1    <= '0;
            y0_s2    <= '0;
            t_s2     <= '0;
            inv_sqrt <= '0;
        end else begin
            x_s1     <= x;
            y0_s1    <= seed;
            // x*y0 first so the product stays in range for small x
            t_s2     <= fp_mul(fp_mul(x_s1, y0_s1), y0_s1);
            y0_s2    <= y0_s1;
            // newton step y0 * (1.5 - x*y0^2/2)
            inv_sqrt <= fp_mul(y0_s2, (FP_ONE + (FP_ONE >>> 1)) - (t_s2 >>> 1));
        end
    end

endmodule

// ==== design/scene_query.sv ====
`timescale 1ns/1ps

module scene_query
    import vector_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  vec3  pos,
    output fp    closest_distance
);

    vec3 offset;
    fp   dist_sq;
    fp   dist_sq_dly [ISQRT_LAT];
    fp   inv_len;

    assign offset = vec3_sub(pos, SPHERE_CENTER);

    always_ff @(posedge clk) begin
        if (rst) begin
            dist_sq          <= '0;
            dist_sq_dly      <= '{default: '0};
            closest_distance <= '0;
        end else begin
            dist_sq        <= vec3_dot(offset, offset);
            // squared length waits for its inverse root
            dist_sq_dly[0] <= dist_sq;
            for (int i = 1; i < ISQRT_LAT; i++) begin
                dist_sq_dly[i] <= dist_sq_dly[i-1];
            end
            // |d| = d^2 / sqrt(d^2)
            closest_distance <= fp_mul(dist_sq_dly[ISQRT_LAT-1], inv_len) - SPHERE_RADIUS;
        end
    end

    inv_sqrt len_isqrt_inst (
        .clk      (clk),
        .rst      (rst),
        .x        (dist_sq),
        .inv_sqrt (inv_len)
    );

endmodule

// ==== surface/surface_vectors.sv ====
`timescale 1ns/1ps

module surface_vectors
    import vector_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    input  shade_req      in_req,
    output logic          out_valid,
    output surface_sample out_sample
);

    vec3                 probe_pos [4];
    fp                   probe_dist [4];
    vec3                 light_pipe [SCENE_LAT + 1];
    vec3                 normal_vec;
    vec3                 normal_pipe [ISQRT_LAT + 1];
    vec3                 light_vec_pipe [ISQRT_LAT + 1];
    fp                   normal_sq;
    fp                   light_sq;
    fp                   inv_normal_len;
    fp                   inv_light_len;
    logic [SURF_LAT-1:0] valid_pipe;
    pixel_tag            tag_pipe [SURF_LAT];

    for (genvar i = 0; i < 4; i++) begin : g_probe
        scene_query probe_query_inst (
            .clk              (clk),
            .rst              (rst),
            .pos              (probe_pos[i]),
            .closest_distance (probe_dist[i])
        );
    end

    // gradient estimate, sum of corner direction times distance
    always_comb begin
        normal_vec = '0;
        for (int i = 0; i < 4; i++) begin
            normal_vec = vec3_add(normal_vec, vec3_scale(TETRA_DIR[i], probe_dist[i]));
        end
        normal_vec = vec3_scale(normal_vec, NORMAL_GAIN);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            probe_pos[i] <= vec3_add(in_req.p, vec3_scale(TETRA_DIR[i], PROBE_EPS));
        end

        // light vector rides along while the probes are queried
        light_pipe[0] <= vec3_scale(vec3_sub(in_req.light_pos, in_req.p), LIGHT_GAIN);
        for (int k = 1; k <= SCENE_LAT; k++) begin
            light_pipe[k] <= light_pipe[k-1];
        end

        normal_pipe[0]    <= normal_vec;
        normal_sq         <= vec3_dot(normal_vec, normal_vec);
        light_vec_pipe[0] <= light_pipe[SCENE_LAT];
        light_sq          <= vec3_dot(light_pipe[SCENE_LAT], light_pipe[SCENE_LAT]);
        for (int k = 1; k <= ISQRT_LAT; k++) begin
            normal_pipe[k]    <= normal_pipe[k-1];
            light_vec_pipe[k] <= light_vec_pipe[k-1];
        end

        tag_pipe[0] <= in_req.tag;
        for (int k = 1; k < SURF_LAT; k++) begin
            tag_pipe[k] <= tag_pipe[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[SURF_LAT-2:0], in_valid};
        end
    end

    inv_sqrt normal_isqrt_inst (
        .clk      (clk),
        .rst      (rst),
        .x        (normal_sq),
        .inv_sqrt (inv_normal_len)
    );

    inv_sqrt light_isqrt_inst (
        .clk      (clk),
        .rst      (rst),
        .x        (light_sq),
        .inv_sqrt (inv_light_len)
    );

    // final normalize straight off the inverse root registers
    assign out_valid            = valid_pipe[SURF_LAT-1];
    assign out_sample.tag       = tag_pipe[SURF_LAT-1];
    assign out_sample.normal    = vec3_scale(normal_pipe[ISQRT_LAT], inv_normal_len);
    assign out_sample.light_dir = vec3_scale(light_vec_pipe[ISQRT_LAT], inv_light_len);

endmodule

// ==== design/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo
    import vector_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          wr_valid,
    input  surface_sample wr_data,
    output logic          rd_valid,
    input  logic          rd_ready,
    output surface_sample rd_data,
    output slot_count     free_slots
);

    surface_sample mem [FIFO_DEPTH];
    fifo_ptr       wr_ptr;
    fifo_ptr       rd_ptr;
    slot_count     count;
    logic          rd_fire;

    assign rd_valid   = count != '0;
    assign rd_fire    = rd_valid && rd_ready;
    assign rd_data    = mem[rd_ptr];
    assign free_slots = slot_count'(FIFO_DEPTH) - count;

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + slot_count'(wr_valid) - slot_count'(rd_fire);
        end
    end

endmodule

// ==== design/diffuse_shade.sv ====
`timescale 1ns/1ps

module diffuse_shade
    import vector_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    output logic          in_ready,
    input  surface_sample in_sample,
    output logic          out_valid,
    input  logic          out_ready,
    output shade_result   out_res
);

    fp    lambert;
    logic accept;

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;
    assign lambert  = vec3_dot(in_sample.normal, in_sample.light_dir);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_res.tag       <= in_sample.tag;
            // surfaces facing away from the light get nothing
            out_res.intensity <= lambert[31] ? '0 : lambert;
            out_res.normal    <= in_sample.normal;
        end
    end

endmodule

// ==== design/shading_core.sv ====
`timescale 1ns/1ps

module shading_core
    import vector_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  shade_req    in_req,
    output logic        out_valid,
    input  logic        out_ready,
    output shade_result out_res
);

    logic          accept;
    logic          sv_valid;
    surface_sample sv_sample;
    logic          fifo_valid;
    logic          fifo_ready;
    surface_sample fifo_data;
    slot_count     free_slots;
    slot_count     in_flight;

    // every sample in the pipeline already owns a FIFO slot
    assign in_ready = free_slots > in_flight;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + slot_count'(accept) - slot_count'(sv_valid);
        end
    end

    surface_vectors surface_vectors_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (accept),
        .in_req     (in_req),
        .out_valid  (sv_valid),
        .out_sample (sv_sample)
    );

    sample_fifo sample_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .wr_valid   (sv_valid),
        .wr_data    (sv_sample),
        .rd_valid   (fifo_valid),
        .rd_ready   (fifo_ready),
        .rd_data    (fifo_data),
        .free_slots (free_slots)
    );

    diffuse_shade diffuse_shade_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .in_sample (fifo_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

endmodule

// ==== test/shading_core_tb.sv ====
`timescale 1ns/1ps

module shading_core_tb
    import vector_pkg::*;
;

    localparam int  NUM_REQ        = 200;
    localparam int  TIMEOUT_CYCLES = NUM_REQ * 4 + SURF_LAT + 200;
    localparam real TOL            = 1.0 / 256.0;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    shade_req    in_req;
    logic        out_valid;
    logic        out_ready;
    shade_result out_res;

    integer      seed;
    int          cycles;
    int          errors;
    int          error_mark;
    int          accepted;
    int          received;
    int          target;
    logic        back_pressure;
    logic        stalled;
    shade_result held_res;
    pixel_tag    next_tag;
    real         pend_n [3];
    real         pend_dot;

    // model results for accepted requests, oldest first
    pixel_tag exp_tags [$];
    real      exp_nx [$];
    real      exp_ny [$];
    real      exp_nz [$];
    real      exp_dots [$];

    shading_core shading_core_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    always #20 clk = ~clk;

    function automatic fp real_to_fp(real r);
        return fp'($rtoi(r * 16777216.0));
    endfunction

    function automatic real fp_to_real(fp v);
        return $itor(v) / 16777216.0;
    endfunction

    function automatic real abs_diff(real a, real b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic real rand_unit();
        return $itor($random(seed) % 1000000) / 1000000.0;
    endfunction

    // hit point near the sphere surface and light anywhere in the box
    task automatic build_request(output shade_req req);
        real d [3];
        real c [3];
        real p [3];
        real l [3];
        real len;
        real radius;
        real l_len;
        real n_len;
        c[0] = fp_to_real(SPHERE_CENTER.x);
        c[1] = fp_to_real(SPHERE_CENTER.y);
        c[2] = fp_to_real(SPHERE_CENTER.z);
        len = 0.0;
        while (len < 0.1) begin
            for (int i = 0; i < 3; i++) begin
                d[i] = rand_unit();
            end
            len = $sqrt(d[0] * d[0] + d[1] * d[1] + d[2] * d[2]);
        end
        radius = fp_to_real(SPHERE_RADIUS) + 0.01 * rand_unit();
        for (int i = 0; i < 3; i++) begin
            p[i] = fp_to_real(real_to_fp(c[i] + d[i] / len * radius));
        end
        req.p = make_vec3(real_to_fp(p[0]), real_to_fp(p[1]), real_to_fp(p[2]));
        l_len = 0.0;
        while (l_len < 0.5) begin
            req.light_pos = make_vec3(real_to_fp(8.0 * rand_unit()),
                                      real_to_fp(8.0 * rand_unit()),
                                      real_to_fp(8.0 * rand_unit()));
            l[0] = fp_to_real(req.light_pos.x) - p[0];
            l[1] = fp_to_real(req.light_pos.y) - p[1];
            l[2] = fp_to_real(req.light_pos.z) - p[2];
            l_len = $sqrt(l[0] * l[0] + l[1] * l[1] + l[2] * l[2]);
        end
        n_len = $sqrt((p[0] - c[0]) ** 2 + (p[1] - c[1]) ** 2 + (p[2] - c[2]) ** 2);
        pend_dot = 0.0;
        for (int i = 0; i < 3; i++) begin
            pend_n[i] = (p[i] - c[i]) / n_len;
            pend_dot  = pend_dot + pend_n[i] * l[i] / l_len;
        end
        req.tag  = next_tag;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic check_output();
        real exp_n [3];
        real got_n [3];
        real exp_dot;
        pixel_tag exp_tag;
        received++;
        assert (exp_tags.size() > 0) else begin
            $display("ERROR %0t: tag %0d arrived with no request pending", $time, out_res.tag);
            errors++;
        end
        if (exp_tags.size() == 0) return;
        exp_tag  = exp_tags.pop_front();
        exp_n[0] = exp_nx.pop_front();
        exp_n[1] = exp_ny.pop_front();
        exp_n[2] = exp_nz.pop_front();
        exp_dot  = exp_dots.pop_front();
        got_n[0] = fp_to_real(out_res.normal.x);
        got_n[1] = fp_to_real(out_res.normal.y);
        got_n[2] = fp_to_real(out_res.normal.z);
        assert (out_res.tag == exp_tag) else begin
            $display("ERROR %0t: tag %0d, expected %0d", $time, out_res.tag, exp_tag);
            errors++;
        end
        for (int i = 0; i < 3; i++) begin
            assert (abs_diff(got_n[i], exp_n[i]) <= TOL) else begin
                $display("ERROR %0t: tag %0d normal[%0d] %f, expected %f",
                         $time, exp_tag, i, got_n[i], exp_n[i]);
                errors++;
            end
        end
        if (exp_dot < -TOL) begin
            assert (out_res.intensity == '0) else begin
                $display("ERROR %0t: tag %0d back-facing intensity %f, expected 0",
                         $time, exp_tag, fp_to_real(out_res.intensity));
                errors++;
            end
        end else begin
            assert (abs_diff(fp_to_real(out_res.intensity),
                             (exp_dot > 0.0) ? exp_dot : 0.0) <= TOL)
            else begin
                $display("ERROR %0t: tag %0d intensity %f, expected %f",
                         $time, exp_tag, fp_to_real(out_res.intensity), exp_dot);
                errors++;
            end
        end
    endtask

    task automatic report_test(string name);
        $display("test %s done: %0d errors", name, errors - error_mark);
        error_mark = errors;
    endtask

    // drive requests and check responses on every rising edge
    always @(posedge clk) begin
        shade_req req;
        if (!rst) begin
            if (accepted == 0) begin
                assert (!out_valid) else begin
                    $display("ERROR %0t: out_valid high before any request", $time);
                    errors++;
                end
            end
            if (stalled) begin
                assert (out_valid && out_res == held_res) else begin
                    $display("ERROR %0t: output changed while stalled", $time);
                    errors++;
                end
            end
            stalled  = out_valid && !out_ready;
            held_res = out_res;
            if (out_valid && out_ready) begin
                check_output();
            end
            if (in_valid && in_ready) begin
                exp_tags.push_back(in_req.tag);
                exp_nx.push_back(pend_n[0]);
                exp_ny.push_back(pend_n[1]);
                exp_nz.push_back(pend_n[2]);
                exp_dots.push_back(pend_dot);
                accepted++;
            end
            if (!in_valid || in_ready) begin
                if (accepted < target && (($random(seed) & 32'h7fff_ffff) % 10) < 8) begin
                    build_request(req);
                    in_req   <= req;
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            if (back_pressure) begin
                out_ready <= (($random(seed) & 32'h7fff_ffff) % 10) < 3;
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d outputs received",
                     cycles, received, NUM_REQ);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        seed          = 60870;
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_req        = '0;
        out_ready     = 1'b0;
        cycles        = 0;
        errors        = 0;
        error_mark    = 0;
        accepted      = 0;
        received      = 0;
        target        = 0;
        back_pressure = 1'b0;
        stalled       = 1'b0;
        next_tag      = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (in_ready) else begin
            $display("ERROR %0t: in_ready low after reset", $time);
            errors++;
        end
        target = NUM_REQ / 2;
        while (accepted == 0) @(negedge clk);
        report_test("reset");
        while (received < NUM_REQ / 2) @(negedge clk);
        report_test("streaming");
        // out_ready high about 30 % of the time from here on
        back_pressure = 1'b1;
        target        = NUM_REQ;
        while (received < NUM_REQ) @(negedge clk);
        report_test("back_pressure");
        repeat (SURF_LAT + 4) @(negedge clk);
        assert (received == accepted && exp_tags.size() == 0) else begin
            $display("ERROR %0t: %0d accepted but %0d received", $time, accepted, received);
            errors++;
        end
        report_test("ordering");
        $display("summary: %0d accepted, %0d received, %0d errors", accepted, received, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== shading.f ====
common/vector_pkg.sv
design/inv_sqrt.sv
design/scene_query.sv
surface/surface_vectors.sv
design/sample_fifo.sv
design/diffuse_shade.sv
design/shading_core.sv
test/shading_core_tb.sv

// ==== Bender.yml ====
package:
  name: shading

sources:
  - common/vector_pkg.sv
  - design/inv_sqrt.sv
  - design/scene_query.sv
  - surface/surface_vectors.sv
  - design/sample_fifo.sv
  - design/diffuse_shade.sv
  - design/shading_core.sv
  - target: test
    files:
      - test/shading_core_tb.sv
